// File: pe.f
pe_pkg.sv
sdp_bram.sv
data_mem.sv
inst_seq.sv
cplx_alu.sv
pe_core.sv
pe_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = pe_tb
FILELIST  = pe.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: pe_tb.sv
module pe_tb
  import pe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // run length in clock cycles

  localparam int clk_period = 8;
  localparam int n_init     = 6;  // random words at 0 and up
  localparam int n_xfer     = 4;
  localparam int n_corner   = 4;  // overflow corner words after the random ones
  localparam int n_prog     = 7;
  localparam int len_t1     = n_init + 1 + (n_init + 4);
  localparam int len_t2     = n_xfer + 1 + (n_xfer + 4);
  localparam int len_t3     = n_corner + 1 + (2 * n_prog + n_prog * issue_gap + 10) + (n_prog + 4);
  localparam int len_t5     = (issue_gap + 11) + 3 + (1 + 4) + (2 + 4);
  localparam int len_t6     = (2 * issue_gap + 12) + 2 * (1 + 4);
  localparam int limit_cycles = 2 * (5 + len_t1 + len_t2 + len_t3 + len_t5 + len_t6);

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       load_valid;
  cplx_t                      load_data;
  logic                       xfer_valid;
  cplx_t                      xfer_data;
  logic                       prog_we;
  logic [prog_addr_width-1:0] prog_addr;
  inst_t                      prog_inst;
  logic                       start;
  logic [prog_len_width-1:0]  prog_len;
  logic                       busy;
  logic                       done;
  logic                       dump_start;
  logic [dm_addr_width-1:0]   dump_addr;
  logic                       dump_shift;
  logic                       dump_valid;
  cplx_t                      dump_data;

  cplx_t                    model [dm_depth];  // expected memory contents
  logic [dm_addr_width-1:0] load_ptr = '0;
  logic [dm_addr_width-1:0] xfer_ptr = dm_addr_width'(xfer_base);
  inst_t                    prog_q [$];        // program being built
  int                       value_errs = 0;
  int                       other_errs = 0;

  always #(clk_period / 2) clk = ~clk;

  pe_core uut (.*);

  ////////////////////////////////////////
  // compare tasks

  task automatic check_cplx(input string name, input cplx_t exp, input cplx_t act);
    if (act !== exp) begin
      value_errs++;
      $display("Fail %0t %s: expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("Fail %0t %s: expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      value_errs++;
      $display("Fail %0t %s: expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // reference model and drivers

  // add and sub wrap and products keep bits 30 to 15
  function automatic cplx_t alu_model(input op_e op, input cplx_t a, input cplx_t b);
    cplx_t  r;
    longint ar;
    longint ai;
    longint br;
    longint bi;
    longint pr;
    longint pi;
    ar = longint'($signed(a.re));
    ai = longint'($signed(a.im));
    br = longint'($signed(b.re));
    bi = longint'($signed(b.im));
    case (op)
      op_add: begin
        r.re = a.re + b.re;
        r.im = a.im + b.im;
      end
      op_sub: begin
        r.re = a.re - b.re;
        r.im = a.im - b.im;
      end
      default: begin
        pr   = ar * br - ai * bi;  // exact in 64 bits
        pi   = ar * bi + ai * br;
        r.re = pr[30:15];
        r.im = pi[30:15];
      end
    endcase
    return r;
  endfunction

  function automatic cplx_t rand_word();
    return cplx_t'($urandom);
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    load_valid <= 1'b0;
    xfer_valid <= 1'b0;
    prog_we    <= 1'b0;
    start      <= 1'b0;
    dump_start <= 1'b0;
    dump_shift <= 1'b0;
  endtask

  task automatic load_word(input cplx_t w);
    @(posedge clk);
    load_valid <= 1'b1;
    load_data  <= w;
    model[load_ptr] = w;
    load_ptr++;  // wraps like the dut counter
  endtask

  task automatic xfer_word(input cplx_t w);
    @(posedge clk);
    xfer_valid <= 1'b1;
    xfer_data  <= w;
    model[xfer_ptr] = w;
    xfer_ptr++;
  endtask

  task automatic add_inst(input op_e op, input int s1, input int s2, input int d);
    inst_t i;
    i.op   = op;
    i.src1 = dm_addr_width'(s1);
    i.src2 = dm_addr_width'(s2);
    i.dst  = dm_addr_width'(d);
    prog_q.push_back(i);
  endtask

  // reads n words from addr and expects valid 2 cycles after each shift
  task automatic dump_check(input logic [dm_addr_width-1:0] addr, input int n);
    logic [dm_addr_width-1:0] a;
    a = addr;
    @(posedge clk);
    dump_start <= 1'b1;
    dump_addr  <= addr;
    for (int j = 0; j < n + 3; j++) begin
      @(posedge clk);
      dump_start <= 1'b0;
      dump_shift <= (j < n);
      @(negedge clk);
      check_bit("dump_valid", (j >= 2) && (j < n + 2), dump_valid);
      if ((j >= 2) && (j < n + 2)) begin
        check_cplx($sformatf("dump_data[%0d]", a), model[a], dump_data);
        a++;
      end
    end
  endtask

  // write prog_q, start, wait for done, then fold it into the model
  task automatic run_program();
    int  expect_cycles;
    int  k;
    bit  seen;
    expect_cycles = prog_q.size() * issue_gap + 8;
    foreach (prog_q[i]) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= prog_addr_width'(i);
      prog_inst <= prog_q[i];
    end
    @(posedge clk);
    prog_we  <= 1'b0;
    prog_len <= prog_len_width'(prog_q.size());
    start    <= 1'b1;
    k    = 0;
    seen = 1'b0;
    while (!seen && k < expect_cycles + 16) begin
      @(posedge clk);
      start <= 1'b0;
      k++;
      @(negedge clk);
      if (done === 1'b1) begin
        seen = 1'b1;
      end else begin
        check_bit("busy", 1'b1, busy);  // high for the whole run
      end
    end
    if (seen) begin
      check_count("cycles start to done", expect_cycles, k);
      check_bit("busy", 1'b0, busy);
      @(posedge clk);
      @(negedge clk);
      check_bit("done", 1'b0, done);  // one cycle only
    end else begin
      other_errs++;
      $display("done did not arrive within %0d cycles of start", k);
    end
    foreach (prog_q[i]) begin
      if (prog_q[i].op != op_nop) begin
        model[prog_q[i].dst] = alu_model(prog_q[i].op, model[prog_q[i].src1],
                                         model[prog_q[i].src2]);
      end
    end
    prog_q.delete();
  endtask

  ////////////////////////////////////////
  // directed tests

  task automatic initial_load_dump();
    @(negedge clk);
    check_bit("busy", 1'b0, busy);
    check_bit("done", 1'b0, done);
    check_bit("dump_valid", 1'b0, dump_valid);
    for (int i = 0; i < n_init; i++) begin
      load_word(rand_word());
    end
    idle_cycle();
    dump_check('0, n_init);
  endtask

  task automatic neighbour_xfer();
    for (int i = 0; i < n_xfer; i++) begin
      xfer_word(rand_word());
    end
    idle_cycle();
    dump_check(dm_addr_width'(xfer_base), n_xfer);
  endtask

  task automatic mixed_alu_program();
    load_word('{re: 16'h7fff, im: 16'h4000});  // addr 6
    load_word('{re: 16'h0001, im: 16'h8000});  // addr 7
    load_word('{re: 16'h8000, im: 16'h8000});  // addr 8 holds -1 -1
    load_word('{re: 16'h7fff, im: 16'h7fff});  // addr 9
    idle_cycle();
    add_inst(op_add, 6, 9, 64);   // both parts wrap
    add_inst(op_sub, 7, 6, 65);   // wraps negative
    add_inst(op_mul, 8, 8, 66);   // im hits 2^31
    add_inst(op_mul, 0, 1, 67);   // random operands with truncation
    add_inst(op_add, 67, 2, 68);  // earlier dst as source
    add_inst(op_sub, 3, 68, 69);
    add_inst(op_mul, 64, 65, 70);
    run_program();
    dump_check(8'd64, n_prog);
  endtask

  task automatic same_cycle_collision();
    cplx_t                    lw;
    cplx_t                    xw0;
    cplx_t                    xw1;
    logic [dm_addr_width-1:0] ld_addr;
    logic [dm_addr_width-1:0] drop_addr;
    add_inst(op_add, 0, 1, int'(xfer_ptr));  // known word where the drop would land
    run_program();
    lw  = rand_word();
    xw0 = rand_word();
    xw1 = rand_word();
    @(posedge clk);
    load_valid <= 1'b1;
    load_data  <= lw;
    xfer_valid <= 1'b1;
    xfer_data  <= xw0;
    ld_addr   = load_ptr;
    drop_addr = xfer_ptr;
    model[load_ptr] = lw;
    load_ptr++;
    xfer_ptr++;  // xw0 lost but the pointer still moves
    @(posedge clk);
    load_valid <= 1'b0;
    xfer_data  <= xw1;
    model[xfer_ptr] = xw1;
    xfer_ptr++;
    idle_cycle();
    dump_check(ld_addr, 1);
    dump_check(drop_addr, 2);
  endtask

  task automatic nop_keeps_dst();
    add_inst(op_nop, 2, 3, 64);  // 64 must keep its value
    add_inst(op_add, 2, 3, 71);
    run_program();
    dump_check(8'd64, 1);
    dump_check(8'd71, 1);
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    void'($urandom(61534));
    rst        <= 1'b1;
    load_valid <= 1'b0;
    load_data  <= '0;
    xfer_valid <= 1'b0;
    xfer_data  <= '0;
    prog_we    <= 1'b0;
    prog_addr  <= '0;
    prog_inst  <= '0;
    start      <= 1'b0;
    prog_len   <= '0;
    dump_start <= 1'b0;
    dump_addr  <= '0;
    dump_shift <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    initial_load_dump();
    neighbour_xfer();
    mixed_alu_program();
    same_cycle_collision();
    nop_keeps_dst();
    idle_cycle();
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // stops a hung run
  initial begin
    #(limit_cycles * clk_period);
    $display("simulation ran past %0d cycles and was stopped", limit_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

// File: pe_core.sv
// processing element top
// sequencer, data memory and alu behind the host ports
module pe_core
  import pe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  // host load
  input  logic                       load_valid,
  input  cplx_t                      load_data,
  // neighbour transfer
  input  logic                       xfer_valid,
  input  cplx_t                      xfer_data,
  // program write
  input  logic                       prog_we,
  input  logic [prog_addr_width-1:0] prog_addr,
  input  inst_t                      prog_inst,
  // run control
  input  logic                       start,
  input  logic [prog_len_width-1:0]  prog_len,
  output logic                       busy,
  output logic                       done,
  // dump
  input  logic                       dump_start,
  input  logic [dm_addr_width-1:0]   dump_addr,
  input  logic                       dump_shift,
  output logic                       dump_valid,
  output cplx_t                      dump_data
);

  logic     inst_v;
  inst_t    inst;
  logic     op_v;
  op_e      op;
  cplx_t    douta;
  cplx_t    doutb;
  alu_res_t wb;

  inst_seq u_inst_seq (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_inst (prog_inst),
    .start     (start),
    .prog_len  (prog_len),
    .inst_v    (inst_v),
    .inst      (inst),
    .op_v      (op_v),
    .op        (op),
    .busy      (busy),
    .done      (done)
  );

  data_mem u_data_mem (
    .clk        (clk),
    .rst        (rst),
    .load_valid (load_valid),
    .load_data  (load_data),
    .xfer_valid (xfer_valid),
    .xfer_data  (xfer_data),
    .inst_v     (inst_v),
    .inst       (inst),
    .wb         (wb),
    .dump_start (dump_start),
    .dump_addr  (dump_addr),
    .dump_shift (dump_shift),
    .douta      (douta),
    .doutb      (doutb),
    .dump_valid (dump_valid)
  );

  cplx_alu u_cplx_alu (
    .clk  (clk),
    .rst  (rst),
    .op_v (op_v),
    .op   (op),
    .a    (douta),
    .b    (doutb),
    .wb   (wb)
  );

  assign dump_data = douta;  // bank a output doubles as dump data

endmodule

// File: cplx_alu.sv
// two stage complex alu
// q1.15 add, sub and multiply, truncation and wrap-around
module cplx_alu
  import pe_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     op_v,
  input  op_e      op,
  input  cplx_t    a,
  input  cplx_t    b,
  output alu_res_t wb
);

  ////////////////////////////////////////
  // stage one

  logic                           s1_v;   // result expected next stage
  op_e                            s1_op;
  logic signed [2*data_width-1:0] p_rr;   // a.re * b.re
  logic signed [2*data_width-1:0] p_ii;   // a.im * b.im
  logic signed [2*data_width-1:0] p_ri;   // a.re * b.im
  logic signed [2*data_width-1:0] p_ir;   // a.im * b.re
  cplx_t                          s1_sum; // add or sub, already wrapped

  logic signed [2*data_width-1:0] mul_re;
  logic signed [2*data_width-1:0] mul_im;
  cplx_t                          res;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_v <= 1'b0;
    end else begin
      s1_v <= op_v && (op != op_nop);  // nop never writes back
    end
    s1_op <= op;
    p_rr  <= $signed(a.re) * $signed(b.re);
    p_ii  <= $signed(a.im) * $signed(b.im);
    p_ri  <= $signed(a.re) * $signed(b.im);
    p_ir  <= $signed(a.im) * $signed(b.re);
    if (op == op_sub) begin
      s1_sum.re <= a.re - b.re;  // 16 bit wrap
      s1_sum.im <= a.im - b.im;
    end else begin
      s1_sum.re <= a.re + b.re;
      s1_sum.im <= a.im + b.im;
    end
  end

  ////////////////////////////////////////
  // stage two

  // combine at 32 bits, then drop the extra sign bit and the low 15
  always_comb begin
    mul_re = p_rr - p_ii;
    mul_im = p_ri + p_ir;
    if (s1_op == op_mul) begin
      res.re = mul_re[2*data_width-2:data_width-1];
      res.im = mul_im[2*data_width-2:data_width-1];
    end else begin
      res = s1_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= s1_v;  // data memory writes on the next edge
    end
    wb.data <= res;
  end

  // program store and opcode delay hand over a defined op
  a_op_known : assert property (@(posedge clk) disable iff (rst)
    op_v |-> !$isunknown(op))
    else $error("unknown opcode at alu input");

endmodule

// File: inst_seq.sv
// program store and issuer
// one instruction every issue_gap cycles, done after the last write-back
module inst_seq
  import pe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       prog_we,
  input  logic [prog_addr_width-1:0] prog_addr,
  input  inst_t                      prog_inst,
  input  logic                       start,
  input  logic [prog_len_width-1:0]  prog_len,
  output logic                       inst_v,
  output inst_t                      inst,
  output logic                       op_v,
  output op_e                        op,
  output logic                       busy,
  output logic                       done
);

  logic [prog_len_width-1:0] pc;       // next instruction to fetch
  logic [gap_width-1:0]      gap_cnt;  // position inside the issue slot
  logic [run_width-1:0]      run_cnt;  // cycles since start
  logic [run_width-1:0]      run_end;
  logic                      fetch_go;
  logic                      fetch_d;  // fetch one cycle old
  logic [op_delay-1:0]       opv_sr;
  op_e                       op_sr [op_delay];

  // prefetch at the head of each slot, out of the store two cycles later
  assign fetch_go = busy && (gap_cnt == '0) && (pc < prog_len);

  // run_cnt is 0 in the first busy cycle, done goes high the cycle after the match
  assign run_end = run_width'(prog_len * issue_gap + run_tail - 2);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      pc      <= '0;
      gap_cnt <= '0;
      run_cnt <= '0;
      fetch_d <= 1'b0;
      inst_v  <= 1'b0;
      opv_sr  <= '0;
    end else begin
      fetch_d <= fetch_go;
      inst_v  <= fetch_d;  // with the store output
      opv_sr  <= {opv_sr[op_delay-2:0], inst_v};
      done    <= 1'b0;
      if (start && !busy) begin
        busy    <= 1'b1;
        pc      <= '0;
        gap_cnt <= '0;
        run_cnt <= '0;
      end else if (busy) begin
        run_cnt <= run_cnt + 1'b1;
        if (gap_cnt == gap_width'(issue_gap - 1)) begin
          gap_cnt <= '0;
        end else begin
          gap_cnt <= gap_cnt + 1'b1;
        end
        if (fetch_go) begin
          pc <= pc + 1'b1;
        end
        if (run_cnt == run_end) begin  // last result is in memory
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // opcode waits for the operands to come out of the banks
  always_ff @(posedge clk) begin
    op_sr[0] <= inst.op;
    for (int i = 1; i < op_delay; i++) begin
      op_sr[i] <= op_sr[i-1];
    end
  end

  assign op_v = opv_sr[op_delay-1];
  assign op   = op_sr[op_delay-1];

  sdp_bram #(
    .word_t (inst_t),
    .depth  (prog_depth)
  ) prog_store (
    .clk   (clk),
    .rst   (rst),  // clears dout to an op_nop word
    .we    (prog_we),
    .waddr (prog_addr),
    .din   (prog_inst),
    .re    (fetch_go),
    .raddr (pc[prog_addr_width-1:0]),
    .dout  (inst)
  );

  // the host waits for done before starting again
  a_no_restart : assert property (@(posedge clk) disable iff (rst)
    start |-> !busy)
    else $error("start pulsed while busy");

endmodule

// File: data_mem.sv
// dual bank data memory
// both banks hold the same words so src1 and src2 read in the same cycle
module data_mem
  import pe_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     load_valid,
  input  cplx_t                    load_data,
  input  logic                     xfer_valid,
  input  cplx_t                    xfer_data,
  input  logic                     inst_v,
  input  inst_t                    inst,
  input  alu_res_t                 wb,
  input  logic                     dump_start,
  input  logic [dm_addr_width-1:0] dump_addr,
  input  logic                     dump_shift,
  output cplx_t                    douta,
  output cplx_t                    doutb,
  output logic                     dump_valid
);

  logic [dm_addr_width-1:0] load_cnt;  // host load pointer
  logic [dm_addr_width-1:0] xfer_cnt;  // neighbour transfer pointer
  logic [dm_addr_width-1:0] raddr_a;   // src1, also the dump pointer
  logic [dm_addr_width-1:0] raddr_b;   // src2
  logic [dm_addr_width-1:0] wb_addr;   // dst of the instruction in flight
  logic [dm_addr_width-1:0] wb_addr_dl [wb_delay];

  logic                     rd_pend;   // issue seen, read enable next
  logic                     rden;
  logic                     re_a;
  logic [rd_latency-1:0]    dump_sr;   // one bit per ram stage

  logic                     wr_en;
  logic [dm_addr_width-1:0] wr_addr;
  cplx_t                    wr_data;

  ////////////////////////////////////////
  // address counters

  always_ff @(posedge clk) begin
    if (rst) begin
      load_cnt <= '0;
      xfer_cnt <= dm_addr_width'(xfer_base);
      raddr_a  <= '0;
      raddr_b  <= '0;
      rd_pend  <= 1'b0;
      rden     <= 1'b0;
    end else begin
      if (load_valid) begin
        load_cnt <= load_cnt + 1'b1;
      end
      if (xfer_valid) begin
        xfer_cnt <= xfer_cnt + 1'b1;  // advances even when the word is dropped
      end

      if (inst_v) begin
        raddr_a <= inst.src1;
        raddr_b <= inst.src2;
      end else if (dump_start) begin
        raddr_a <= dump_addr;
      end else if (dump_shift) begin
        raddr_a <= raddr_a + 1'b1;  // read current word, step on
      end

      rd_pend <= inst_v;   // addresses latched this edge
      rden    <= rd_pend;  // operands out two edges later
    end
  end

  // destination rides along until the alu result comes back
  always_ff @(posedge clk) begin
    if (inst_v) begin
      wb_addr <= inst.dst;
    end
    wb_addr_dl[0] <= wb_addr;
    for (int i = 1; i < wb_delay; i++) begin
      wb_addr_dl[i] <= wb_addr_dl[i-1];
    end
  end

  ////////////////////////////////////////
  // write port, load > write-back > transfer

  always_comb begin
    wr_en   = 1'b1;
    wr_addr = load_cnt;
    wr_data = load_data;
    if (load_valid) begin
      wr_addr = load_cnt;
      wr_data = load_data;
    end else if (wb.valid) begin
      wr_addr = wb_addr_dl[wb_delay-1];
      wr_data = wb.data;
    end else if (xfer_valid) begin
      wr_addr = xfer_cnt;
      wr_data = xfer_data;
    end else begin
      wr_en = 1'b0;  // idle
    end
  end

  ////////////////////////////////////////
  // dump path

  assign re_a = rden | dump_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      dump_sr <= '0;
    end else begin
      dump_sr <= {dump_sr[rd_latency-2:0], dump_shift};
    end
  end

  assign dump_valid = dump_sr[rd_latency-1];  // lines up with douta

  // bank a serves src1 and the dump port
  sdp_bram #(
    .word_t (cplx_t),
    .depth  (dm_depth)
  ) data_bank_a (
    .clk   (clk),
    .rst   (rst),
    .we    (wr_en),
    .waddr (wr_addr),
    .din   (wr_data),
    .re    (re_a),
    .raddr (raddr_a),
    .dout  (douta)
  );

  // bank b serves src2
  sdp_bram #(
    .word_t (cplx_t),
    .depth  (dm_depth)
  ) data_bank_b (
    .clk   (clk),
    .rst   (rst),
    .we    (wr_en),
    .waddr (wr_addr),
    .din   (wr_data),
    .re    (rden),
    .raddr (raddr_b),
    .dout  (doutb)
  );

  // an alu result that meets a host load is gone for good
  a_wb_not_lost : assert property (@(posedge clk) disable iff (rst)
    wb.valid |-> !load_valid)
    else $error("write-back to %0d lost to a load", wb_addr_dl[wb_delay-1]);

  // transfer word beaten by load or write-back
  a_xfer_not_lost : assert property (@(posedge clk) disable iff (rst)
    xfer_valid |-> !(load_valid || wb.valid))
    else $warning("transfer word for %0d dropped", xfer_cnt);

endmodule

// File: sdp_bram.sv
// simple dual port ram, one clock
// write in one cycle, read through two registers
module sdp_bram #(
  parameter type word_t = logic [31:0],
  parameter int  depth  = 256
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] waddr,
  input  word_t                    din,
  input  logic                     re,
  input  logic [$clog2(depth)-1:0] raddr,
  output word_t                    dout
);

  word_t mem [depth];
  word_t mem_q;  // first read stage, inside the ram primitive

  // write port and first read stage
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= din;
    end
    if (re) begin
      mem_q <= mem[raddr];  // holds while re is low
    end
  end

  // output register, the only state that rst touches
  always_ff @(posedge clk) begin
    if (rst) begin
      dout <= '0;
    end else begin
      dout <= mem_q;
    end
  end

endmodule

// File: pe_pkg.sv
package pe_pkg;

  ////////////////////////////////////////
  // sizes

  localparam int data_width      = 16;  // one part of a sample, q1.15
  localparam int dm_addr_width   = 8;
  localparam int dm_depth        = 256;
  localparam int xfer_base       = 128;  // neighbour words land from here up
  localparam int prog_addr_width = 4;
  localparam int prog_depth      = 16;
  localparam int prog_len_width  = prog_addr_width + 1;  // 0 to 16 instructions

  ////////////////////////////////////////
  // timing

  localparam int issue_gap  = 8;  // one instruction per 8 cycles, no hazards
  localparam int gap_width  = $clog2(issue_gap);
  localparam int rd_latency = 2;  // memory reg plus output reg
  localparam int wb_delay   = 4;  // dst carried from issue to write-back

  // issue edge to the cycle the operands sit on the ram outputs
  localparam int op_delay = rd_latency + 2;

  // cycles past the last issue slot before done
  localparam int run_tail  = 8;
  localparam int run_width = $clog2(prog_depth * issue_gap + run_tail + 1);

  ////////////////////////////////////////
  // types

  typedef enum logic [7:0] {
    op_nop = 8'h00,  // no write-back
    op_add = 8'h01,
    op_sub = 8'h02,
    op_mul = 8'h03
  } op_e;

  // one complex sample, re in the upper half
  typedef struct packed {
    logic [data_width-1:0] re;
    logic [data_width-1:0] im;
  } cplx_t;

  // three-address instruction, opcode in the top byte
  typedef struct packed {
    op_e                      op;
    logic [dm_addr_width-1:0] src2;  // read from bank b
    logic [dm_addr_width-1:0] src1;  // read from bank a
    logic [dm_addr_width-1:0] dst;
  } inst_t;

  // alu result on its way back to the data memory
  typedef struct packed {
    logic  valid;
    cplx_t data;
  } alu_res_t;

endpackage
